//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_rv_core
FLIST = rv_core.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/alu.sv
`default_nettype none

`include "core_macros.svh"

module alu (
	input  core_pkg::alu_op_e	op_i,
	input  logic [`XLEN-1:0]	a_i,
	input  logic [`XLEN-1:0]	b_i,
	input  logic [2:0]		branch_f3_i,
	output logic [`XLEN-1:0]	result_o,
	output logic			branch_taken_o
);
	import core_pkg::*;

	logic [4:0] shamt;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b_i[4:0];
	assign eq = (a_i == b_i);
	assign lt = ($signed(a_i) < $signed(b_i));
	assign ltu = (a_i < b_i);

	always_comb begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_SLT: result_o = {{(`XLEN-1){1'b0}}, lt};
			ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, ltu};
			ALU_SLL: result_o = a_i << shamt;
			ALU_SRL: result_o = a_i >> shamt;
			ALU_SRA: result_o = $unsigned($signed(a_i) >>> shamt);
			default: result_o = '0;
		endcase
	end

	// branch compare on rs1/rs2, signed for blt/bge
	always_comb begin
		case (branch_f3_i)
			`F3_BEQ: branch_taken_o = eq;
			`F3_BNE: branch_taken_o = !eq;
			`F3_BLT: branch_taken_o = lt;
			`F3_BGE: branch_taken_o = !lt;
			default: branch_taken_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/core_ctrl.sv
`default_nettype none

module core_ctrl (
	input  logic			clock,
	input  logic			rst_i,
	input  logic			imem_ready_i,
	input  logic			imem_rvalid_i,
	input  logic			dmem_ready_i,
	input  logic			dmem_resp_i,
	input  core_pkg::inst_class_e	inst_class_i,
	input  logic			branch_taken_i,
	output logic			imem_req_o,
	output logic			dmem_req_o,
	output logic			inst_load_o,
	output logic			pc_advance_o,
	output logic			pc_jump_o,
	output logic			reg_we_o,
	output logic			halt_o
);
	import core_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	// next state and single-cycle strobes
	always_comb begin
		state_d = state_q;
		inst_load_o = 1'b0;
		pc_advance_o = 1'b0;
		pc_jump_o = 1'b0;
		reg_we_o = 1'b0;
		case (state_q)
			S_FETCH: begin
				if (imem_req_o && imem_ready_i) begin
					state_d = S_WAIT_INST;
				end
			end
			S_WAIT_INST: begin
				if (imem_rvalid_i) begin
					inst_load_o = 1'b1;
					state_d = S_EXEC;
				end
			end
			S_EXEC: begin
				case (inst_class_i)
					C_ALU, C_LUI: begin
						reg_we_o = 1'b1;
						pc_advance_o = 1'b1;
						state_d = S_FETCH;
					end
					C_JAL: begin
						reg_we_o = 1'b1;
						pc_jump_o = 1'b1;
						state_d = S_FETCH;
					end
					C_BRANCH: begin
						pc_jump_o = branch_taken_i;
						pc_advance_o = !branch_taken_i;
						state_d = S_FETCH;
					end
					// pc moves on now, the access only needs the instruction register
					C_LOAD, C_STORE: begin
						pc_advance_o = 1'b1;
						state_d = S_MEM_REQ;
					end
					default: state_d = S_HALT;
				endcase
			end
			S_MEM_REQ: begin
				if (dmem_req_o && dmem_ready_i) begin
					state_d = S_MEM_WAIT;
				end
			end
			S_MEM_WAIT: begin
				if (dmem_resp_i) begin
					reg_we_o = (inst_class_i == C_LOAD);
					state_d = S_FETCH;
				end
			end
			default: state_d = S_HALT;
		endcase
	end

	// request and halt flops follow the next state
	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= S_FETCH;
			imem_req_o <= 1'b0;
			dmem_req_o <= 1'b0;
			halt_o <= 1'b0;
		end else begin
			state_q <= state_d;
			imem_req_o <= (state_d == S_FETCH);
			dmem_req_o <= (state_d == S_MEM_REQ);
			halt_o <= (state_d == S_HALT);
		end
	end

	// instruction register must still hold the memory op during the access
	a_mem_class: assert property (@(posedge clock) disable iff (rst_i)
		dmem_req_o |-> (inst_class_i == C_LOAD || inst_class_i == C_STORE));

	a_imem_hold: assert property (@(posedge clock) disable iff (rst_i)
		imem_req_o && !imem_ready_i |=> imem_req_o);

	a_dmem_hold: assert property (@(posedge clock) disable iff (rst_i)
		dmem_req_o && !dmem_ready_i |=> dmem_req_o);

endmodule

`default_nettype wire

//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

	// register-register layout
	typedef struct packed {
		logic [6:0]	funct7;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} r_view_t;

	// immediate layout, also the source of U and J fields
	typedef struct packed {
		logic [11:0]	imm;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	rd;
		logic [6:0]	opcode;
	} i_view_t;

	// store layout, B immediate is a scrambled copy of it
	typedef struct packed {
		logic [6:0]	imm_hi;
		logic [4:0]	rs2;
		logic [4:0]	rs1;
		logic [2:0]	funct3;
		logic [4:0]	imm_lo;
		logic [6:0]	opcode;
	} s_view_t;

	typedef union packed {
		r_view_t	r;
		i_view_t	i;
		s_view_t	s;
	} rv_inst_u;

	typedef enum logic [2:0] {
		S_FETCH,
		S_WAIT_INST,
		S_EXEC,
		S_MEM_REQ,
		S_MEM_WAIT,
		S_HALT
	} ctrl_state_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		C_ALU,
		C_LUI,
		C_LOAD,
		C_STORE,
		C_BRANCH,
		C_JAL,
		C_EBREAK,
		C_ILLEGAL
	} inst_class_e;

endpackage

`default_nettype wire

//--- design/decoder.sv
`default_nettype none

`include "core_macros.svh"

module decoder (
	input  core_pkg::rv_inst_u	inst_i,
	output logic [`REG_AW-1:0]	rs1_o,
	output logic [`REG_AW-1:0]	rs2_o,
	output logic [`REG_AW-1:0]	rd_o,
	output logic [`XLEN-1:0]	imm_o,
	output core_pkg::alu_op_e	alu_op_o,
	output logic			use_imm_o,
	output core_pkg::inst_class_e	inst_class_o,
	output logic [2:0]		branch_f3_o
);
	import core_pkg::*;

	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [2:0] f3;
	logic alt;
	logic shift;
	alu_op_e base_op;

	assign rs1_o = inst_i.r.rs1;
	assign rs2_o = inst_i.r.rs2;
	assign rd_o = inst_i.r.rd;
	assign branch_f3_o = inst_i.r.funct3;
	assign f3 = inst_i.r.funct3;
	assign alt = (inst_i.r.funct7 == `F7_ALT);
	assign shift = (f3 == `F3_SLL) || (f3 == `F3_SRL_SRA);

	// sign-extended immediates
	assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
	assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
	assign imm_b = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0], inst_i.s.imm_hi[5:0],
		inst_i.s.imm_lo[4:1], 1'b0};
	assign imm_u = {inst_i.i.imm, inst_i.i.rs1, inst_i.i.funct3, 12'b0};
	assign imm_j = {{12{inst_i.i.imm[11]}}, inst_i.i.rs1, inst_i.i.funct3, inst_i.i.imm[0],
		inst_i.i.imm[10:1], 1'b0};

	// funct3 map shared by OP and OP-IMM; sub only exists in OP
	always_comb begin
		case (f3)
			`F3_ADD_SUB: base_op = (alt && inst_i.r.opcode == `OPC_OP) ? ALU_SUB : ALU_ADD;
			`F3_SLL: base_op = ALU_SLL;
			`F3_SLT: base_op = ALU_SLT;
			`F3_SLTU: base_op = ALU_SLTU;
			`F3_XOR: base_op = ALU_XOR;
			`F3_SRL_SRA: base_op = alt ? ALU_SRA : ALU_SRL;
			`F3_OR: base_op = ALU_OR;
			default: base_op = ALU_AND;
		endcase
	end

	always_comb begin
		imm_o = imm_i;
		alu_op_o = ALU_ADD;
		use_imm_o = 1'b1;
		inst_class_o = C_ILLEGAL;
		case (inst_i.r.opcode)
			`OPC_OP: begin
				alu_op_o = base_op;
				use_imm_o = 1'b0;
				if (inst_i.r.funct7 == `F7_BASE || (alt && (f3 == `F3_ADD_SUB ||
					f3 == `F3_SRL_SRA))) begin
					inst_class_o = C_ALU;
				end
			end
			`OPC_OP_IMM: begin
				alu_op_o = base_op;
				if (!shift || inst_i.r.funct7 == `F7_BASE || (alt && f3 == `F3_SRL_SRA)) begin
					inst_class_o = C_ALU;
				end
			end
			`OPC_LUI: begin
				imm_o = imm_u;
				inst_class_o = C_LUI;
			end
			`OPC_LOAD: inst_class_o = (f3 == `F3_LW) ? C_LOAD : C_ILLEGAL;
			`OPC_STORE: begin
				imm_o = imm_s;
				inst_class_o = (f3 == `F3_SW) ? C_STORE : C_ILLEGAL;
			end
			`OPC_BRANCH: begin
				imm_o = imm_b;
				use_imm_o = 1'b0;
				if (f3 == `F3_BEQ || f3 == `F3_BNE || f3 == `F3_BLT || f3 == `F3_BGE) begin
					inst_class_o = C_BRANCH;
				end
			end
			`OPC_JAL: begin
				imm_o = imm_j;
				inst_class_o = C_JAL;
			end
			`OPC_SYSTEM: begin
				if (inst_i.i.imm == `IMM_EBREAK && inst_i.i.rs1 == '0 &&
					inst_i.i.funct3 == 3'b000 && inst_i.i.rd == '0) begin
					inst_class_o = C_EBREAK;
				end
			end
			default: inst_class_o = C_ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

//--- design/pc_unit.sv
`default_nettype none

`include "core_macros.svh"

module pc_unit (
	input  logic			clock,
	input  logic			rst_i,
	input  logic			advance_i,
	input  logic			jump_i,
	input  logic [`XLEN-1:0]	target_i,
	output logic [`XLEN-1:0]	pc_o
);

	logic [`XLEN-1:0] pc_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			pc_q <= `RESET_PC;
		end else if (jump_i) begin
			pc_q <= target_i;
		end else if (advance_i) begin
			pc_q <= pc_q + `XLEN'd4;
		end
	end

	assign pc_o = pc_q;

	// controller picks one update per instruction
	a_one_update: assert property (@(posedge clock) disable iff (rst_i)
		!(advance_i && jump_i));

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

`include "core_macros.svh"

module reg_file (
	input  logic			clock,
	input  logic			rst_i,
	input  logic			we_i,
	input  logic [`REG_AW-1:0]	waddr_i,
	input  logic [`REG_AW-1:0]	raddr1_i,
	input  logic [`REG_AW-1:0]	raddr2_i,
	input  logic [`XLEN-1:0]	wdata_i,
	output logic [`XLEN-1:0]	rdata1_o,
	output logic [`XLEN-1:0]	rdata2_o
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// x0 is never written so it keeps its reset zero
	always_ff @(posedge clock) begin
		if (rst_i) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

`include "core_macros.svh"

module rv_core (
	input  logic			clock,
	input  logic			rst_i,
	output logic			imem_req_o,
	output logic [`XLEN-1:0]	imem_addr_o,
	input  logic			imem_ready_i,
	input  logic			imem_rvalid_i,
	input  logic [`XLEN-1:0]	imem_rdata_i,
	output logic			dmem_req_o,
	output logic			dmem_we_o,
	output logic [`XLEN-1:0]	dmem_addr_o,
	output logic [`XLEN-1:0]	dmem_wdata_o,
	input  logic			dmem_ready_i,
	input  logic			dmem_resp_i,
	input  logic [`XLEN-1:0]	dmem_rdata_i,
	output logic			halt_o
);
	import core_pkg::*;

	rv_inst_u inst_q;
	logic inst_load;
	logic pc_advance;
	logic pc_jump;
	logic reg_we;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] wb_data;
	logic [`REG_AW-1:0] rs1;
	logic [`REG_AW-1:0] rs2;
	logic [`REG_AW-1:0] rd;
	alu_op_e alu_op;
	logic use_imm;
	inst_class_e inst_class;
	logic [2:0] branch_f3;
	logic branch_taken;

	// instruction register, stable until the next fetch returns
	always_ff @(posedge clock) begin
		if (inst_load) begin
			inst_q <= imem_rdata_i;
		end
	end

	assign alu_b = use_imm ? imm : rs2_data;
	assign target = pc + imm;

	always_comb begin
		case (inst_class)
			C_LUI: wb_data = imm;
			C_JAL: wb_data = pc + `XLEN'd4;
			C_LOAD: wb_data = dmem_rdata_i;
			default: wb_data = alu_result;
		endcase
	end

	assign imem_addr_o = pc;
	assign dmem_we_o = (inst_class == C_STORE);
	assign dmem_addr_o = alu_result;
	assign dmem_wdata_o = rs2_data;

	core_ctrl u_core_ctrl (
		.clock		(clock),
		.rst_i		(rst_i),
		.imem_ready_i	(imem_ready_i),
		.imem_rvalid_i	(imem_rvalid_i),
		.dmem_ready_i	(dmem_ready_i),
		.dmem_resp_i	(dmem_resp_i),
		.inst_class_i	(inst_class),
		.branch_taken_i	(branch_taken),
		.imem_req_o	(imem_req_o),
		.dmem_req_o	(dmem_req_o),
		.inst_load_o	(inst_load),
		.pc_advance_o	(pc_advance),
		.pc_jump_o	(pc_jump),
		.reg_we_o	(reg_we),
		.halt_o		(halt_o)
	);

	pc_unit u_pc_unit (
		.clock		(clock),
		.rst_i		(rst_i),
		.advance_i	(pc_advance),
		.jump_i		(pc_jump),
		.target_i	(target),
		.pc_o		(pc)
	);

	decoder u_decoder (
		.inst_i		(inst_q),
		.rs1_o		(rs1),
		.rs2_o		(rs2),
		.rd_o		(rd),
		.imm_o		(imm),
		.alu_op_o	(alu_op),
		.use_imm_o	(use_imm),
		.inst_class_o	(inst_class),
		.branch_f3_o	(branch_f3)
	);

	reg_file u_reg_file (
		.clock		(clock),
		.rst_i		(rst_i),
		.we_i		(reg_we),
		.waddr_i	(rd),
		.raddr1_i	(rs1),
		.raddr2_i	(rs2),
		.wdata_i	(wb_data),
		.rdata1_o	(rs1_data),
		.rdata2_o	(rs2_data)
	);

	alu u_alu (
		.op_i		(alu_op),
		.a_i		(rs1_data),
		.b_i		(alu_b),
		.branch_f3_i	(branch_f3),
		.result_o	(alu_result),
		.branch_taken_o	(branch_taken)
	);

endmodule

`default_nettype wire

//--- include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define XLEN		32
`define REG_AW		5
`define REG_COUNT	32
`define RESET_PC	32'h0000_0000

// major opcodes
`define OPC_OP		7'b0110011
`define OPC_OP_IMM	7'b0010011
`define OPC_LUI		7'b0110111
`define OPC_LOAD	7'b0000011
`define OPC_STORE	7'b0100011
`define OPC_BRANCH	7'b1100011
`define OPC_JAL		7'b1101111
`define OPC_SYSTEM	7'b1110011

// funct3 for alu ops, word access and branches
`define F3_ADD_SUB	3'b000
`define F3_SLL		3'b001
`define F3_SLT		3'b010
`define F3_SLTU		3'b011
`define F3_XOR		3'b100
`define F3_SRL_SRA	3'b101
`define F3_OR		3'b110
`define F3_AND		3'b111
`define F3_LW		3'b010
`define F3_SW		3'b010
`define F3_BEQ		3'b000
`define F3_BNE		3'b001
`define F3_BLT		3'b100
`define F3_BGE		3'b101

// funct7 variants, the alternate one selects sub and sra
`define F7_BASE		7'b0000000
`define F7_ALT		7'b0100000
`define IMM_EBREAK	12'h001

`endif

//--- rv_core.f
+incdir+include
design/core_pkg.sv
design/core_ctrl.sv
design/pc_unit.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/rv_core.sv
tests/tb_rv_core.sv

//--- tests/tb_rv_core.sv
`default_nettype none

`include "core_macros.svh"

module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RUNS = 9;
	localparam int MAX_CYCLES = N_RUNS * 64 * 12;
	localparam int DATA_OFF = 512;
	localparam logic [7:0] DATA_BASE = 8'd128;
	localparam logic [31:0] EBREAK_WORD = {`IMM_EBREAK, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM};

	logic clock = 1'b0;
	logic rst_i = 1'b1;
	logic imem_ready_i = 1'b0;
	logic imem_rvalid_i = 1'b0;
	logic [31:0] imem_rdata_i = '0;
	logic dmem_ready_i = 1'b0;
	logic dmem_resp_i = 1'b0;
	logic [31:0] dmem_rdata_i = '0;
	logic imem_req_o;
	logic [31:0] imem_addr_o;
	logic dmem_req_o;
	logic dmem_we_o;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic halt_o;

	logic [31:0] mem [256];
	logic [7:0] prog_idx;
	logic [31:0] expect_q [$];
	string cur_test = "none";
	integer seed = 46423;
	logic rand_delay = 1'b0;
	int cycle_count = 0;
	logic [11:0] marker_mask;
	logic [31:0] marker_exp;

	// port model state
	logic i_pending;
	logic i_hold;
	logic [31:0] i_hold_addr;
	logic [31:0] i_word;
	int i_ready_wait;
	int i_resp_wait;
	logic d_pending;
	logic d_hold;
	logic [31:0] d_hold_addr;
	logic [31:0] d_hold_data;
	int d_ready_wait;
	int d_resp_wait;

	rv_core dut (
		.clock		(clock),
		.rst_i		(rst_i),
		.imem_req_o	(imem_req_o),
		.imem_addr_o	(imem_addr_o),
		.imem_ready_i	(imem_ready_i),
		.imem_rvalid_i	(imem_rvalid_i),
		.imem_rdata_i	(imem_rdata_i),
		.dmem_req_o	(dmem_req_o),
		.dmem_we_o	(dmem_we_o),
		.dmem_addr_o	(dmem_addr_o),
		.dmem_wdata_o	(dmem_wdata_o),
		.dmem_ready_i	(dmem_ready_i),
		.dmem_resp_i	(dmem_resp_i),
		.dmem_rdata_i	(dmem_rdata_i),
		.halt_o		(halt_o)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: core still running after %0d cycles in %s", MAX_CYCLES,
				cur_test);
			$display("SIMULATION FAILED");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH test=%s %s expected=%h actual=%h", cur_test, what, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "first error");
		end
	endtask

	function automatic int pick_delay();
		if (rand_delay) begin
			return $random(seed) & 3;
		end
		return 0;
	endfunction

	// instruction side of the shared memory
	always @(posedge clock) begin
		imem_rvalid_i <= 1'b0;
		if (rst_i) begin
			imem_ready_i <= 1'b0;
			i_pending = 1'b0;
			i_hold = 1'b0;
			i_ready_wait = pick_delay();
		end else begin
			if (i_hold && imem_req_o) begin
				compare("imem address held", i_hold_addr, imem_addr_o);
			end
			i_hold = imem_req_o && !imem_ready_i;
			i_hold_addr = imem_addr_o;
			if (imem_req_o && imem_ready_i) begin
				i_word = mem[imem_addr_o[9:2]];
				imem_ready_i <= 1'b0;
				i_pending = 1'b1;
				i_resp_wait = pick_delay();
				i_ready_wait = pick_delay();
			end else if (imem_req_o && i_ready_wait == 0) begin
				imem_ready_i <= 1'b1;
			end else if (imem_req_o) begin
				i_ready_wait--;
			end
			if (i_pending) begin
				if (i_resp_wait == 0) begin
					imem_rvalid_i <= 1'b1;
					imem_rdata_i <= i_word;
					i_pending = 1'b0;
				end else begin
					i_resp_wait--;
				end
			end
		end
	end

	// data side, stores land at acceptance
	always @(posedge clock) begin
		dmem_resp_i <= 1'b0;
		if (rst_i) begin
			dmem_ready_i <= 1'b0;
			d_pending = 1'b0;
			d_hold = 1'b0;
			d_ready_wait = pick_delay();
		end else begin
			if (d_hold && dmem_req_o) begin
				compare("dmem address held", d_hold_addr, dmem_addr_o);
				compare("dmem data held", d_hold_data, dmem_wdata_o);
			end
			d_hold = dmem_req_o && !dmem_ready_i;
			d_hold_addr = dmem_addr_o;
			d_hold_data = dmem_wdata_o;
			if (dmem_req_o && dmem_ready_i) begin
				if (dmem_we_o) begin
					mem[dmem_addr_o[9:2]] = dmem_wdata_o;
				end else begin
					dmem_rdata_i <= mem[dmem_addr_o[9:2]];
				end
				dmem_ready_i <= 1'b0;
				d_pending = 1'b1;
				d_resp_wait = pick_delay();
				d_ready_wait = pick_delay();
			end else if (dmem_req_o && d_ready_wait == 0) begin
				dmem_ready_i <= 1'b1;
			end else if (dmem_req_o) begin
				d_ready_wait--;
			end
			if (d_pending) begin
				if (d_resp_wait == 0) begin
					dmem_resp_i <= 1'b1;
					d_pending = 1'b0;
				end else begin
					d_resp_wait--;
				end
			end
		end
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `OPC_LUI};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[prog_idx] = word;
		prog_idx = prog_idx + 8'd1;
	endtask

	task automatic begin_test(input string name);
		cur_test = rand_delay ? {name, "_delay"} : name;
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = '0;
		end
		expect_q.delete();
		prog_idx = 8'd0;
	endtask

	// lui/addi pair, upper part rounded for the sign of the low twelve bits
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		emit(u_type(upper[31:12], rd));
		emit(i_type(`OPC_OP_IMM, `F3_ADD_SUB, rd, rd, value[11:0]));
	endtask

	task automatic store_slot(input logic [4:0] rs2, input logic [31:0] exp);
		logic [11:0] offset;
		offset = 12'(DATA_OFF + 4 * expect_q.size());
		emit(s_type(offset, rs2, 5'd0));
		expect_q.push_back(exp);
	endtask

	task automatic alu_case(input logic [31:0] word, input logic [31:0] exp);
		emit(word);
		store_slot(5'd3, exp);
	endtask

	task automatic run_program();
		rst_i <= 1'b1;
		repeat (5) @(posedge clock);
		rst_i <= 1'b0;
		@(negedge clock);
		while (!halt_o) @(negedge clock);
		// halted core stays halted and silent
		repeat (8) begin
			@(negedge clock);
			compare("halt held", 32'd1, {31'b0, halt_o});
			compare("no fetch after halt", 32'd0, {31'b0, imem_req_o});
		end
		@(posedge clock);
	endtask

	task automatic check_slots();
		for (int i = 0; i < expect_q.size(); i++) begin
			compare($sformatf("slot %0d", i), expect_q[i], mem[DATA_BASE + 8'(i)]);
		end
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'hF000_1234;
		b = 32'h0000_0F0F;
		begin_test("alu");
		load_const(5'd1, a);
		load_const(5'd2, b);
		alu_case(r_type(`F7_BASE, `F3_ADD_SUB, 5'd3, 5'd1, 5'd2), a + b);
		alu_case(r_type(`F7_ALT, `F3_ADD_SUB, 5'd3, 5'd1, 5'd2), a - b);
		alu_case(r_type(`F7_BASE, `F3_AND, 5'd3, 5'd1, 5'd2), a & b);
		alu_case(r_type(`F7_BASE, `F3_OR, 5'd3, 5'd1, 5'd2), a | b);
		alu_case(r_type(`F7_BASE, `F3_XOR, 5'd3, 5'd1, 5'd2), a ^ b);
		alu_case(r_type(`F7_BASE, `F3_SLT, 5'd3, 5'd1, 5'd2),
			($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		alu_case(r_type(`F7_BASE, `F3_SLTU, 5'd3, 5'd1, 5'd2), (a < b) ? 32'd1 : 32'd0);
		alu_case(r_type(`F7_BASE, `F3_SLTU, 5'd3, 5'd2, 5'd1), (b < a) ? 32'd1 : 32'd0);
		alu_case(r_type(`F7_BASE, `F3_SLL, 5'd3, 5'd1, 5'd2), a << b[4:0]);
		alu_case(r_type(`F7_BASE, `F3_SRL_SRA, 5'd3, 5'd1, 5'd2), a >> b[4:0]);
		alu_case(r_type(`F7_ALT, `F3_SRL_SRA, 5'd3, 5'd1, 5'd2),
			$unsigned($signed(a) >>> b[4:0]));
		alu_case(i_type(`OPC_OP_IMM, `F3_ADD_SUB, 5'd3, 5'd1, 12'hFFB), a + 32'hFFFF_FFFB);
		alu_case(i_type(`OPC_OP_IMM, `F3_SLT, 5'd3, 5'd1, 12'hFFF),
			($signed(a) < -32'sd1) ? 32'd1 : 32'd0);
		alu_case(i_type(`OPC_OP_IMM, `F3_SLTU, 5'd3, 5'd1, 12'hFFF),
			(a < 32'hFFFF_FFFF) ? 32'd1 : 32'd0);
		alu_case(i_type(`OPC_OP_IMM, `F3_XOR, 5'd3, 5'd1, 12'h7FF), a ^ 32'h0000_07FF);
		alu_case(i_type(`OPC_OP_IMM, `F3_AND, 5'd3, 5'd1, 12'h0F0), a & 32'h0000_00F0);
		alu_case(i_type(`OPC_OP_IMM, `F3_OR, 5'd3, 5'd1, 12'h800), a | 32'hFFFF_F800);
		alu_case(i_type(`OPC_OP_IMM, `F3_SLL, 5'd3, 5'd1, 12'h003), a << 3);
		alu_case(i_type(`OPC_OP_IMM, `F3_SRL_SRA, 5'd3, 5'd1, 12'h009), a >> 9);
		alu_case(i_type(`OPC_OP_IMM, `F3_SRL_SRA, 5'd3, 5'd1, 12'h407),
			$unsigned($signed(a) >>> 7));
		emit(EBREAK_WORD);
		run_program();
		check_slots();
	endtask

	task automatic test_const();
		begin_test("lui_addi");
		load_const(5'd1, 32'h8000_0800);
		store_slot(5'd1, 32'h8000_0800);
		load_const(5'd2, 32'h7FFF_FFFF);
		store_slot(5'd2, 32'h7FFF_FFFF);
		load_const(5'd3, 32'hFFFF_F800);
		store_slot(5'd3, 32'hFFFF_F800);
		load_const(5'd4, 32'h1234_5FFF);
		store_slot(5'd4, 32'h1234_5FFF);
		// x0 as destination, the slot is pre-filled so a zero store shows
		emit(i_type(`OPC_OP_IMM, `F3_ADD_SUB, 5'd0, 5'd0, 12'h07B));
		emit(u_type(20'hABCDE, 5'd0));
		mem[DATA_BASE + 8'd4] = 32'hFFFF_FFFF;
		store_slot(5'd0, 32'h0000_0000);
		emit(EBREAK_WORD);
		run_program();
		check_slots();
	endtask

	task automatic test_load();
		begin_test("load");
		mem[DATA_BASE + 8'd16] = 32'h1234_5678;
		emit(i_type(`OPC_LOAD, `F3_LW, 5'd5, 5'd0, 12'h240));
		emit(i_type(`OPC_OP_IMM, `F3_ADD_SUB, 5'd5, 5'd5, 12'h001));
		store_slot(5'd5, 32'h1234_5679);
		emit(s_type(12'h240, 5'd5, 5'd0));
		load_const(5'd6, 32'h0000_0200);
		emit(i_type(`OPC_LOAD, `F3_LW, 5'd7, 5'd6, 12'h040));
		store_slot(5'd7, 32'h1234_5679);
		load_const(5'd8, 32'hCAFE_F00D);
		store_slot(5'd8, 32'hCAFE_F00D);
		emit(i_type(`OPC_LOAD, `F3_LW, 5'd9, 5'd0, 12'h208));
		store_slot(5'd9, 32'hCAFE_F00D);
		emit(EBREAK_WORD);
		run_program();
		check_slots();
		compare("word stored back", 32'h1234_5679, mem[DATA_BASE + 8'd16]);
	endtask

	// taken branch jumps over its marker addi on x10
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b);
		logic taken;
		case (f3)
			`F3_BEQ: taken = (a == b);
			`F3_BNE: taken = (a != b);
			`F3_BLT: taken = ($signed(a) < $signed(b));
			default: taken = ($signed(a) >= $signed(b));
		endcase
		emit(b_type(f3, rs1, rs2, 13'd8));
		emit(i_type(`OPC_OP_IMM, `F3_ADD_SUB, 5'd10, 5'd10, marker_mask));
		if (!taken) begin
			marker_exp = marker_exp | {20'b0, marker_mask};
		end
		marker_mask = marker_mask << 1;
	endtask

	task automatic test_branch();
		logic [31:0] ret;
		begin_test("branch");
		marker_mask = 12'h001;
		marker_exp = '0;
		load_const(5'd1, 32'd5);
		load_const(5'd2, 32'hFFFF_FFFD);
		load_const(5'd3, 32'd5);
		branch_case(`F3_BEQ, 5'd1, 5'd3, 32'd5, 32'd5);
		branch_case(`F3_BEQ, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branch_case(`F3_BNE, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branch_case(`F3_BNE, 5'd1, 5'd3, 32'd5, 32'd5);
		branch_case(`F3_BLT, 5'd2, 5'd1, 32'hFFFF_FFFD, 32'd5);
		branch_case(`F3_BLT, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branch_case(`F3_BGE, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branch_case(`F3_BGE, 5'd2, 5'd1, 32'hFFFF_FFFD, 32'd5);
		branch_case(`F3_BGE, 5'd1, 5'd3, 32'd5, 32'd5);
		store_slot(5'd10, marker_exp);
		// jal over one marker, link is its own address plus four
		ret = {22'b0, prog_idx, 2'b00} + 32'd4;
		emit(j_type(21'd8, 5'd11));
		emit(i_type(`OPC_OP_IMM, `F3_ADD_SUB, 5'd12, 5'd0, 12'h001));
		store_slot(5'd11, ret);
		store_slot(5'd12, 32'd0);
		emit(EBREAK_WORD);
		run_program();
		check_slots();
	endtask

	task automatic test_halt();
		begin_test("ebreak");
		load_const(5'd1, 32'h0000_00AA);
		store_slot(5'd1, 32'h0000_00AA);
		emit(EBREAK_WORD);
		store_slot(5'd1, 32'd0);
		run_program();
		check_slots();
		begin_test("illegal");
		load_const(5'd1, 32'h0000_00BB);
		store_slot(5'd1, 32'h0000_00BB);
		emit(32'h0000_0000);
		store_slot(5'd1, 32'd0);
		run_program();
		check_slots();
	endtask

	initial begin
		test_alu();
		test_const();
		test_load();
		test_branch();
		// same programs under random handshake delays
		rand_delay = 1'b1;
		test_alu();
		test_load();
		test_branch();
		rand_delay = 1'b0;
		test_halt();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
